//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tl_mem_subsystem.f --top-module tl_mem_subsystem_tb

run: compile
	./obj_dir/Vtl_mem_subsystem_tb | tee sim.log
	@if grep -q "sim failed" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "sim passed" sim.log; then \
		echo "simulation did not complete"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- hw/tl_mem_pkg.sv
`include "tl_mem_defs.svh"

package tl_mem_pkg;

	// access sizes as seen on the processor memory port.
	typedef enum logic [1:0] {
		MEM_ACCESS_SIZE_BYTE,
		MEM_ACCESS_SIZE_HALF,
		MEM_ACCESS_SIZE_WORD
	} mem_access_size_t;

	// **************************************************************************
	// TL-UL opcodes
	// **************************************************************************

	typedef enum logic [2:0] {
		TL_CHANNEL_A_OPCODE_PUT_FULL_DATA    = 3'd0,
		TL_CHANNEL_A_OPCODE_PUT_PARTIAL_DATA = 3'd1,
		TL_CHANNEL_A_OPCODE_GET              = 3'd4
	} tl_a_opcode_t;

	typedef enum logic [2:0] {
		TL_CHANNEL_D_OPCODE_ACCESS_ACK      = 3'd0,
		TL_CHANNEL_D_OPCODE_ACCESS_ACK_DATA = 3'd1
	} tl_d_opcode_t;

	// **************************************************************************
	// widths
	// **************************************************************************

	// log2 of the number of bytes in a transfer.
	typedef logic [1:0] tl_size_t;

	typedef logic [`TL_ADDR_WIDTH-1:0] tl_addr_t;
	typedef logic [8*`TL_DATA_BYTES-1:0] tl_data_t;
	typedef logic [`TL_DATA_BYTES-1:0] tl_mask_t;

	// word index into the RAM.
	typedef logic [$clog2(`TL_RAM_WORDS)-1:0] ram_index_t;

endpackage

//--- hw/tl_mem_subsystem.sv
`timescale 1ns/100ps

module tl_mem_subsystem (
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic                         rd_enable,
	input  tl_mem_pkg::tl_addr_t         rd_addr,
	input  tl_mem_pkg::mem_access_size_t rd_size,
	input  logic                         wr_enable,
	input  tl_mem_pkg::tl_addr_t         wr_addr,
	input  tl_mem_pkg::mem_access_size_t wr_size,
	input  tl_mem_pkg::tl_data_t         wr_data,
	output logic                         busy,
	output tl_mem_pkg::tl_data_t         rd_data,
	output logic                         err
);
	import tl_mem_pkg::*;

	// **************************************************************************
	// TL-UL A and D channels
	// **************************************************************************

	logic         a_valid;
	logic         a_ready;
	tl_a_opcode_t a_opcode;
	logic [2:0]   a_param;
	tl_size_t     a_size;
	tl_addr_t     a_address;
	tl_mask_t     a_mask;
	tl_data_t     a_data;
	logic         d_valid;
	logic         d_ready;
	tl_d_opcode_t d_opcode;
	tl_size_t     d_size;
	logic         d_denied;
	tl_data_t     d_data;

	// RAM port.
	ram_index_t ram_index;
	logic       ram_wr_en;
	tl_mask_t   ram_byte_en;
	tl_data_t   ram_wr_data;
	tl_data_t   ram_rd_data;

	tl_memory_controller_master i_master (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.rd_enable (rd_enable),
		.rd_addr   (rd_addr),
		.rd_size   (rd_size),
		.wr_enable (wr_enable),
		.wr_addr   (wr_addr),
		.wr_size   (wr_size),
		.wr_data   (wr_data),
		.busy      (busy),
		.rd_data   (rd_data),
		.err       (err),
		.a_valid   (a_valid),
		.a_ready   (a_ready),
		.a_opcode  (a_opcode),
		.a_param   (a_param),
		.a_size    (a_size),
		.a_address (a_address),
		.a_mask    (a_mask),
		.a_data    (a_data),
		.d_valid   (d_valid),
		.d_ready   (d_ready),
		.d_opcode  (d_opcode),
		.d_size    (d_size),
		.d_denied  (d_denied),
		.d_data    (d_data)
	);

	tl_ram_slave i_slave (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.a_valid     (a_valid),
		.a_ready     (a_ready),
		.a_opcode    (a_opcode),
		.a_param     (a_param),
		.a_size      (a_size),
		.a_address   (a_address),
		.a_mask      (a_mask),
		.a_data      (a_data),
		.d_valid     (d_valid),
		.d_ready     (d_ready),
		.d_opcode    (d_opcode),
		.d_size      (d_size),
		.d_denied    (d_denied),
		.d_data      (d_data),
		.ram_index   (ram_index),
		.ram_wr_en   (ram_wr_en),
		.ram_byte_en (ram_byte_en),
		.ram_wr_data (ram_wr_data),
		.ram_rd_data (ram_rd_data)
	);

	tl_ram_array i_ram (
		.clk_i       (clk_i),
		.ram_index   (ram_index),
		.ram_wr_en   (ram_wr_en),
		.ram_byte_en (ram_byte_en),
		.ram_wr_data (ram_wr_data),
		.ram_rd_data (ram_rd_data)
	);

endmodule

//--- hw/tl_memory_controller_master.sv
`timescale 1ns/100ps

module tl_memory_controller_master (
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic                         rd_enable,
	input  tl_mem_pkg::tl_addr_t         rd_addr,
	input  tl_mem_pkg::mem_access_size_t rd_size,
	input  logic                         wr_enable,
	input  tl_mem_pkg::tl_addr_t         wr_addr,
	input  tl_mem_pkg::mem_access_size_t wr_size,
	input  tl_mem_pkg::tl_data_t         wr_data,
	output logic                         busy,
	output tl_mem_pkg::tl_data_t         rd_data,
	output logic                         err,
	output logic                         a_valid,
	input  logic                         a_ready,
	output tl_mem_pkg::tl_a_opcode_t     a_opcode,
	output logic [2:0]                   a_param,
	output tl_mem_pkg::tl_size_t         a_size,
	output tl_mem_pkg::tl_addr_t         a_address,
	output tl_mem_pkg::tl_mask_t         a_mask,
	output tl_mem_pkg::tl_data_t         a_data,
	input  logic                         d_valid,
	output logic                         d_ready,
	input  tl_mem_pkg::tl_d_opcode_t     d_opcode,
	input  tl_mem_pkg::tl_size_t         d_size,
	input  logic                         d_denied,
	input  tl_mem_pkg::tl_data_t         d_data
);
	import tl_mem_pkg::*;

	localparam int offset_bits = $clog2($bits(tl_mask_t));

	typedef enum logic [1:0] {
		READY,
		DO_GET,
		DO_PUT_FULL_DATA,
		DO_PUT_PARTIAL_DATA
	} state_t;

	state_t state, next_state;

	logic                   a_pending;
	logic                   start;
	logic                   resp_done;
	tl_d_opcode_t           expected_opcode;
	tl_addr_t               sel_addr;
	mem_access_size_t       sel_size;
	logic [offset_bits-1:0] sel_offset;
	tl_size_t               req_size;
	logic [offset_bits-1:0] req_offset;
	tl_addr_t               req_address;
	tl_mask_t               req_mask;
	tl_data_t               req_data;
	tl_data_t               shifted_data;
	tl_data_t               return_data;

	function automatic tl_size_t size_to_tl_size(mem_access_size_t size);
		case (size)
			MEM_ACCESS_SIZE_BYTE: return tl_size_t'(0);
			MEM_ACCESS_SIZE_HALF: return tl_size_t'(1);
			default:              return tl_size_t'(2);
		endcase
	endfunction

	function automatic tl_mask_t size_to_mask(mem_access_size_t size);
		case (size)
			MEM_ACCESS_SIZE_BYTE: return tl_mask_t'(1);
			MEM_ACCESS_SIZE_HALF: return tl_mask_t'(3);
			default:              return '1;
		endcase
	endfunction

	// low address bits that the access size cannot use are dropped here.
	function automatic logic [offset_bits-1:0] lane_offset(tl_addr_t addr, mem_access_size_t size);
		logic [offset_bits-1:0] offset;
		offset = addr[offset_bits-1:0];
		case (size)
			MEM_ACCESS_SIZE_BYTE: return offset;
			MEM_ACCESS_SIZE_HALF: return {offset[offset_bits-1:1], 1'b0};
			default:              return '0;
		endcase
	endfunction

	// **************************************************************************
	// request capture
	// **************************************************************************

	assign start      = (state == READY) && (rd_enable || wr_enable);
	assign sel_addr   = rd_enable ? rd_addr : wr_addr;
	assign sel_size   = rd_enable ? rd_size : wr_size;
	assign sel_offset = lane_offset(sel_addr, sel_size);

	always_ff @(posedge clk_i) begin
		if (start) begin
			req_size    <= size_to_tl_size(sel_size);
			req_offset  <= sel_offset;
			req_address <= {sel_addr[$bits(tl_addr_t)-1:offset_bits], sel_offset};
			req_mask    <= size_to_mask(sel_size) << sel_offset;
			req_data    <= rd_enable ? '0 : wr_data << {sel_offset, 3'b000};
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			READY: begin
				if (rd_enable) begin
					next_state = DO_GET;
				end else if (wr_enable) begin
					if (wr_size == MEM_ACCESS_SIZE_WORD) begin
						next_state = DO_PUT_FULL_DATA;
					end else begin
						next_state = DO_PUT_PARTIAL_DATA;
					end
				end
			end
			default: begin
				if (resp_done) begin
					next_state = READY;
				end
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state     <= READY;
			a_pending <= 1'b0;
		end else begin
			state <= next_state;
			if (start) begin
				a_pending <= 1'b1;
			end else if (a_valid && a_ready) begin
				a_pending <= 1'b0;
			end
		end
	end

	// **************************************************************************
	// A channel
	// **************************************************************************

	assign busy      = state != READY;
	assign a_valid   = a_pending;
	assign a_param   = '0;
	assign a_size    = req_size;
	assign a_address = req_address;
	assign a_mask    = req_mask;
	assign a_data    = req_data;

	always_comb begin
		case (state)
			DO_PUT_FULL_DATA:    a_opcode = TL_CHANNEL_A_OPCODE_PUT_FULL_DATA;
			DO_PUT_PARTIAL_DATA: a_opcode = TL_CHANNEL_A_OPCODE_PUT_PARTIAL_DATA;
			default:             a_opcode = TL_CHANNEL_A_OPCODE_GET;
		endcase
	end

	// **************************************************************************
	// response return
	// **************************************************************************

	// the response is only taken once the request has left on the A channel.
	assign d_ready = busy && !a_pending;

	assign expected_opcode = (state == DO_GET) ? TL_CHANNEL_D_OPCODE_ACCESS_ACK_DATA :
		TL_CHANNEL_D_OPCODE_ACCESS_ACK;
	assign resp_done = d_valid && d_ready && (d_opcode == expected_opcode) && (d_size == req_size);

	assign shifted_data = d_data >> {req_offset, 3'b000};

	always_comb begin
		case (req_size)
			tl_size_t'(0): return_data = shifted_data & tl_data_t'(8'hff);
			tl_size_t'(1): return_data = shifted_data & tl_data_t'(16'hffff);
			default:       return_data = shifted_data;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			rd_data <= '0;
			err     <= 1'b0;
		end else if (resp_done) begin
			rd_data <= return_data;
			err     <= d_denied;
		end
	end

endmodule

//--- hw/tl_ram_array.sv
`timescale 1ns/100ps
`include "tl_mem_defs.svh"

module tl_ram_array (
	input  logic                   clk_i,
	input  tl_mem_pkg::ram_index_t ram_index,
	input  logic                   ram_wr_en,
	input  tl_mem_pkg::tl_mask_t   ram_byte_en,
	input  tl_mem_pkg::tl_data_t   ram_wr_data,
	output tl_mem_pkg::tl_data_t   ram_rd_data
);
	import tl_mem_pkg::*;

	// each word is kept as byte lanes so a lane can be written alone.
	logic [`TL_DATA_BYTES-1:0][7:0] mem [`TL_RAM_WORDS];

	always_ff @(posedge clk_i) begin
		if (ram_wr_en) begin
			for (int lane = 0; lane < `TL_DATA_BYTES; lane++) begin
				if (ram_byte_en[lane]) begin
					mem[ram_index][lane] <= ram_wr_data[8*lane +: 8];
				end
			end
		end
	end

	// a read in the same cycle as a write returns the old word.
	always_ff @(posedge clk_i) begin
		ram_rd_data <= tl_data_t'(mem[ram_index]);
	end

endmodule

//--- hw/tl_ram_slave.sv
`timescale 1ns/100ps
`include "tl_mem_defs.svh"

module tl_ram_slave (
	input  logic                     clk_i,
	input  logic                     reset_i,
	input  logic                     a_valid,
	output logic                     a_ready,
	input  tl_mem_pkg::tl_a_opcode_t a_opcode,
	input  logic [2:0]               a_param,
	input  tl_mem_pkg::tl_size_t     a_size,
	input  tl_mem_pkg::tl_addr_t     a_address,
	input  tl_mem_pkg::tl_mask_t     a_mask,
	input  tl_mem_pkg::tl_data_t     a_data,
	output logic                     d_valid,
	input  logic                     d_ready,
	output tl_mem_pkg::tl_d_opcode_t d_opcode,
	output tl_mem_pkg::tl_size_t     d_size,
	output logic                     d_denied,
	output tl_mem_pkg::tl_data_t     d_data,
	output tl_mem_pkg::ram_index_t   ram_index,
	output logic                     ram_wr_en,
	output tl_mem_pkg::tl_mask_t     ram_byte_en,
	output tl_mem_pkg::tl_data_t     ram_wr_data,
	input  tl_mem_pkg::tl_data_t     ram_rd_data
);
	import tl_mem_pkg::*;

	localparam int offset_bits = $clog2(`TL_DATA_BYTES);
	localparam tl_addr_t ram_bytes = tl_addr_t'(`TL_RAM_WORDS * `TL_DATA_BYTES);

	typedef enum logic {
		IDLE,
		RESPOND
	} state_t;

	state_t     state;
	logic       a_fire;
	logic       a_is_get;
	logic       a_is_put;
	logic       a_legal;
	logic       resp_is_get;
	logic       resp_denied;
	tl_size_t   resp_size;
	ram_index_t resp_index;

	assign a_ready  = state == IDLE;
	assign a_fire   = a_valid && a_ready;
	assign a_is_get = a_opcode == TL_CHANNEL_A_OPCODE_GET;
	assign a_is_put = (a_opcode == TL_CHANNEL_A_OPCODE_PUT_FULL_DATA) ||
		(a_opcode == TL_CHANNEL_A_OPCODE_PUT_PARTIAL_DATA);

	// an address past the RAM or a malformed message is answered as denied.
	assign a_legal = (a_address < ram_bytes) && (a_param == '0) && (a_is_get || a_is_put);

	// **************************************************************************
	// RAM port
	// **************************************************************************

	// the index is held while responding so the read register keeps its word.
	assign ram_index   = a_ready ? a_address[offset_bits +: $bits(ram_index_t)] : resp_index;
	assign ram_wr_en   = a_fire && a_is_put && a_legal;
	assign ram_byte_en = a_mask;
	assign ram_wr_data = a_data;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:    if (a_fire) state <= RESPOND;
				RESPOND: if (d_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (a_fire) begin
			resp_is_get <= a_is_get;
			resp_denied <= !a_legal;
			resp_size   <= a_size;
			resp_index  <= a_address[offset_bits +: $bits(ram_index_t)];
		end
	end

	// **************************************************************************
	// D channel
	// **************************************************************************

	assign d_valid  = state == RESPOND;
	assign d_opcode = resp_is_get ? TL_CHANNEL_D_OPCODE_ACCESS_ACK_DATA :
		TL_CHANNEL_D_OPCODE_ACCESS_ACK;
	assign d_size   = resp_size;
	assign d_denied = resp_denied;
	assign d_data   = (resp_is_get && !resp_denied) ? ram_rd_data : '0;

endmodule

//--- include/tl_mem_defs.svh
`ifndef TL_MEM_DEFS_SVH
`define TL_MEM_DEFS_SVH

// bytes carried on the TL-UL data bus.
`define TL_DATA_BYTES 4

// width of a byte address.
`define TL_ADDR_WIDTH 32

// words held by the RAM. An address at or above 4 * this is out of range.
`define TL_RAM_WORDS 256

`endif

//--- tl_mem_subsystem.f
+incdir+include
hw/tl_mem_pkg.sv
hw/tl_ram_array.sv
hw/tl_ram_slave.sv
hw/tl_memory_controller_master.sv
hw/tl_mem_subsystem.sv
verification/tl_mem_subsystem_tb.sv

//--- verification/tl_mem_subsystem_tb.sv
`timescale 1ns/100ps
`include "tl_mem_defs.svh"

module tl_mem_subsystem_tb;
	import tl_mem_pkg::*;

	typedef struct {
		bit               is_write;
		mem_access_size_t size;
		tl_addr_t         addr;
		tl_data_t         wdata;
		tl_data_t         exp_rd;
		bit               exp_err;
	} step_t;

	// first byte address past the end of the RAM.
	localparam tl_addr_t out_of_range = tl_addr_t'(4 * `TL_RAM_WORDS);

	logic             clk_i;
	logic             reset_i;
	logic             rd_enable;
	tl_addr_t         rd_addr;
	mem_access_size_t rd_size;
	logic             wr_enable;
	tl_addr_t         wr_addr;
	mem_access_size_t wr_size;
	tl_data_t         wr_data;
	logic             busy;
	tl_data_t         rd_data;
	logic             err;

	step_t steps[$];
	int    mismatch_count;
	int    failure_count;
	bit    stalled;

	tl_mem_subsystem i_dut (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.rd_enable (rd_enable),
		.rd_addr   (rd_addr),
		.rd_size   (rd_size),
		.wr_enable (wr_enable),
		.wr_addr   (wr_addr),
		.wr_size   (wr_size),
		.wr_data   (wr_data),
		.busy      (busy),
		.rd_data   (rd_data),
		.err       (err)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// **************************************************************************
	// stimulus table
	// **************************************************************************

	task automatic add_write(input mem_access_size_t size, input tl_addr_t addr,
		input tl_data_t wdata, input bit exp_err);
		steps.push_back('{1'b1, size, addr, wdata, tl_data_t'(0), exp_err});
	endtask

	task automatic add_read(input mem_access_size_t size, input tl_addr_t addr,
		input tl_data_t exp_rd, input bit exp_err);
		steps.push_back('{1'b0, size, addr, tl_data_t'(0), exp_rd, exp_err});
	endtask

	task automatic build_table();
		// word write and read back.
		add_write(MEM_ACCESS_SIZE_WORD, 32'h10, 32'h64347f30, 1'b0);
		add_read(MEM_ACCESS_SIZE_WORD, 32'h10, 32'h64347f30, 1'b0);

		// single byte lanes over a full word.
		add_write(MEM_ACCESS_SIZE_WORD, 32'h20, 32'h11223344, 1'b0);
		add_write(MEM_ACCESS_SIZE_BYTE, 32'h21, 32'h000000aa, 1'b0);
		add_write(MEM_ACCESS_SIZE_BYTE, 32'h22, 32'h000000bb, 1'b0);
		add_write(MEM_ACCESS_SIZE_BYTE, 32'h23, 32'h000000cc, 1'b0);
		add_read(MEM_ACCESS_SIZE_WORD, 32'h20, 32'hccbbaa44, 1'b0);
		add_read(MEM_ACCESS_SIZE_BYTE, 32'h22, 32'h000000bb, 1'b0);

		// upper halfword of a cleared word.
		add_write(MEM_ACCESS_SIZE_WORD, 32'h30, 32'h00000000, 1'b0);
		add_write(MEM_ACCESS_SIZE_HALF, 32'h32, 32'h0000beef, 1'b0);
		add_read(MEM_ACCESS_SIZE_HALF, 32'h32, 32'h0000beef, 1'b0);
		add_read(MEM_ACCESS_SIZE_WORD, 32'h30, 32'hbeef0000, 1'b0);

		// out of range accesses must not alias onto word 0.
		add_write(MEM_ACCESS_SIZE_WORD, 32'h00, 32'h0f1e2d3c, 1'b0);
		add_read(MEM_ACCESS_SIZE_WORD, out_of_range, 32'h00000000, 1'b1);
		add_write(MEM_ACCESS_SIZE_WORD, out_of_range, 32'hdeadbeef, 1'b1);
		add_read(MEM_ACCESS_SIZE_WORD, 32'h00, 32'h0f1e2d3c, 1'b0);

		// a run of mixed sizes where the last two reads carry low address bits they cannot use.
		add_write(MEM_ACCESS_SIZE_HALF, 32'h40, 32'h00001234, 1'b0);
		add_write(MEM_ACCESS_SIZE_HALF, 32'h42, 32'h00005678, 1'b0);
		add_read(MEM_ACCESS_SIZE_WORD, 32'h40, 32'h56781234, 1'b0);
		add_read(MEM_ACCESS_SIZE_BYTE, 32'h43, 32'h00000056, 1'b0);
		add_read(MEM_ACCESS_SIZE_HALF, 32'h41, 32'h00001234, 1'b0);
		add_read(MEM_ACCESS_SIZE_WORD, 32'h42, 32'h56781234, 1'b0);
	endtask

	// **************************************************************************
	// step driver
	// **************************************************************************

	task automatic run_step(input int idx, output bit timed_out);
		step_t s;
		int    waited;
		s = steps[idx];
		timed_out = 1'b0;
		@(posedge clk_i);
		if (s.is_write) begin
			wr_enable <= 1'b1;
			wr_addr   <= s.addr;
			wr_size   <= s.size;
			wr_data   <= s.wdata;
		end else begin
			rd_enable <= 1'b1;
			rd_addr   <= s.addr;
			rd_size   <= s.size;
		end
		@(posedge clk_i);
		rd_enable <= 1'b0;
		wr_enable <= 1'b0;
		@(negedge clk_i);
		if (busy !== 1'b1) begin
			$display("step %0d: busy did not rise after the request", idx);
			failure_count++;
		end
		waited = 0;
		while (busy !== 1'b0 && waited < 50) begin
			@(negedge clk_i);
			waited++;
		end
		if (busy !== 1'b0) begin
			$display("step %0d: busy never fell", idx);
			failure_count++;
			timed_out = 1'b1;
		end else begin
			if (err !== s.exp_err) begin
				$display("Mismatch step %0d: err expected %h got %h", idx, s.exp_err, err);
				mismatch_count++;
			end
			if (!s.is_write && rd_data !== s.exp_rd) begin
				$display("Mismatch step %0d: rd_data expected %h got %h", idx, s.exp_rd, rd_data);
				mismatch_count++;
			end
		end
	endtask

	initial begin
		int idx;
		reset_i        = 1'b1;
		rd_enable      = 1'b0;
		rd_addr        = '0;
		rd_size        = MEM_ACCESS_SIZE_WORD;
		wr_enable      = 1'b0;
		wr_addr        = '0;
		wr_size        = MEM_ACCESS_SIZE_WORD;
		wr_data        = '0;
		mismatch_count = 0;
		failure_count  = 0;
		stalled        = 1'b0;
		build_table();

		repeat (16) @(posedge clk_i);
		reset_i <= 1'b0;
		@(negedge clk_i);
		if (busy !== 1'b0) begin
			$display("Mismatch after reset: busy expected %h got %h", 1'b0, busy);
			mismatch_count++;
		end
		if (rd_data !== '0) begin
			$display("Mismatch after reset: rd_data expected %h got %h", tl_data_t'(0), rd_data);
			mismatch_count++;
		end
		if (err !== 1'b0) begin
			$display("Mismatch after reset: err expected %h got %h", 1'b0, err);
			mismatch_count++;
		end

		idx = 0;
		while (idx < steps.size() && !stalled) begin
			run_step(idx, stalled);
			idx++;
		end

		$display("%0d mismatches, %0d other errors", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
